// File: common/fft8_pkg.sv
package fft8_pkg;

	// transform size and the index that selects one complex sample.
	localparam int N_POINTS = 8;

	typedef logic [$clog2(N_POINTS)-1:0] idx_t;

	// word format of one real or imaginary part.
	localparam int DEFAULT_DATA_W = 16;
	localparam int DEFAULT_FRAC_W = 14;

	// cos(pi/4) scaled to frac_w fraction bits, rounded to the nearest integer.
	function automatic int twiddle_c(input int frac_w);
		real scale;
		scale = 2.0 ** frac_w;
		return int'(0.70710678 * scale);
	endfunction

endpackage

// File: common/fft8_ucode_pkg.sv
package fft8_ucode_pkg;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_MUL
	} alu_op_e;

	// one address per scalar word, inputs sit at 2k for real and 2k+1 for imaginary.
	typedef enum logic [5:0] {
		X_R0, X_I0, X_R1, X_I1, X_R2, X_I2, X_R3, X_I3,
		X_R4, X_I4, X_R5, X_I5, X_R6, X_I6, X_R7, X_I7,
		S1_R0, S1_I0, S1_R1, S1_I1, S1_R2, S1_I2, S1_R3, S1_I3,
		S1_R4, S1_I4, S1_R5, S1_I5, S1_R6, S1_I6, S1_R7, S1_I7,
		S2_R0, S2_I0, S2_R1, S2_I1, S2_R2, S2_I2, S2_R3, S2_I3,
		S2_R4, S2_I4, S2_R5, S2_I5, S2_R6, S2_I6, S2_R7, S2_I7,
		T_R0, T_I0, T_R1, T_I1, T_R2, T_I2, T_R3, T_I3,
		T_R4, T_I4, T_R5, T_I5, W1_R, W1_I, W3_R, W3_I
	} reg_addr_e;

	typedef struct packed {
		alu_op_e   op;
		reg_addr_e src_a;
		reg_addr_e src_b;
		reg_addr_e dst;
	} ustep_t;

	localparam int PROG_LEN = 60;

	typedef logic [5:0] pc_t;

	// a result is readable two steps after the step that computes it.
	function automatic ustep_t program_step(input pc_t pc);
		ustep_t s;
		case (pc)
			6'd0:  s = '{ALU_ADD, X_R0, X_R4, S1_R0}; // stage 1, pairs (0,4) (2,6) (1,5) (3,7).
			6'd1:  s = '{ALU_ADD, X_I0, X_I4, S1_I0};
			6'd2:  s = '{ALU_SUB, X_R0, X_R4, S1_R1};
			6'd3:  s = '{ALU_SUB, X_I0, X_I4, S1_I1};
			6'd4:  s = '{ALU_ADD, X_R2, X_R6, S1_R2};
			6'd5:  s = '{ALU_ADD, X_I2, X_I6, S1_I2};
			6'd6:  s = '{ALU_SUB, X_R2, X_R6, S1_R3};
			6'd7:  s = '{ALU_SUB, X_I2, X_I6, S1_I3};
			6'd8:  s = '{ALU_ADD, X_R1, X_R5, S1_R4};
			6'd9:  s = '{ALU_ADD, X_I1, X_I5, S1_I4};
			6'd10: s = '{ALU_SUB, X_R1, X_R5, S1_R5};
			6'd11: s = '{ALU_SUB, X_I1, X_I5, S1_I5};
			6'd12: s = '{ALU_ADD, X_R3, X_R7, S1_R6};
			6'd13: s = '{ALU_ADD, X_I3, X_I7, S1_I6};
			6'd14: s = '{ALU_SUB, X_R3, X_R7, S1_R7};
			6'd15: s = '{ALU_SUB, X_I3, X_I7, S1_I7};
			6'd16: s = '{ALU_ADD, S1_R0, S1_R2, S2_R0}; // stage 2, odd outputs rotate by -j.
			6'd17: s = '{ALU_ADD, S1_I0, S1_I2, S2_I0};
			6'd18: s = '{ALU_ADD, S1_R1, S1_I3, S2_R1};
			6'd19: s = '{ALU_SUB, S1_I1, S1_R3, S2_I1};
			6'd20: s = '{ALU_SUB, S1_R0, S1_R2, S2_R2};
			6'd21: s = '{ALU_SUB, S1_I0, S1_I2, S2_I2};
			6'd22: s = '{ALU_SUB, S1_R1, S1_I3, S2_R3};
			6'd23: s = '{ALU_ADD, S1_I1, S1_R3, S2_I3};
			6'd24: s = '{ALU_ADD, S1_R4, S1_R6, S2_R4};
			6'd25: s = '{ALU_ADD, S1_I4, S1_I6, S2_I4};
			6'd26: s = '{ALU_ADD, S1_R5, S1_I7, S2_R5};
			6'd27: s = '{ALU_SUB, S1_I5, S1_R7, S2_I5};
			6'd28: s = '{ALU_SUB, S1_R4, S1_R6, S2_R6};
			6'd29: s = '{ALU_SUB, S1_I4, S1_I6, S2_I6};
			6'd30: s = '{ALU_SUB, S1_R5, S1_I7, S2_R7};
			6'd31: s = '{ALU_ADD, S1_I5, S1_R7, S2_I7};
			6'd32: s = '{ALU_MUL, W1_R, S2_R5, T_R0}; // W8^1 times bin 5 of stage 2.
			6'd33: s = '{ALU_MUL, W1_I, S2_I5, T_I0};
			6'd34: s = '{ALU_MUL, W1_R, S2_I5, T_R1};
			6'd35: s = '{ALU_MUL, W1_I, S2_R5, T_I1};
			6'd36: s = '{ALU_SUB, T_R0, T_I0, T_R2};
			6'd37: s = '{ALU_ADD, T_R1, T_I1, T_I2};
			6'd38: s = '{ALU_MUL, W3_R, S2_R7, T_R3}; // W8^3 times bin 7 of stage 2.
			6'd39: s = '{ALU_MUL, W3_I, S2_I7, T_I3};
			6'd40: s = '{ALU_MUL, W3_R, S2_I7, T_R4};
			6'd41: s = '{ALU_MUL, W3_I, S2_R7, T_I4};
			6'd42: s = '{ALU_SUB, T_R3, T_I3, T_R5};
			6'd43: s = '{ALU_ADD, T_R4, T_I4, T_I5};
			6'd44: s = '{ALU_ADD, S2_R0, S2_R4, X_R0}; // stage 3 writes back in place.
			6'd45: s = '{ALU_ADD, S2_I0, S2_I4, X_I0};
			6'd46: s = '{ALU_SUB, S2_R0, S2_R4, X_R4};
			6'd47: s = '{ALU_SUB, S2_I0, S2_I4, X_I4};
			6'd48: s = '{ALU_ADD, S2_R2, S2_I6, X_R2};
			6'd49: s = '{ALU_SUB, S2_I2, S2_R6, X_I2};
			6'd50: s = '{ALU_SUB, S2_R2, S2_I6, X_R6};
			6'd51: s = '{ALU_ADD, S2_I2, S2_R6, X_I6};
			6'd52: s = '{ALU_ADD, S2_R1, T_R2, X_R1};
			6'd53: s = '{ALU_ADD, S2_I1, T_I2, X_I1};
			6'd54: s = '{ALU_SUB, S2_R1, T_R2, X_R5};
			6'd55: s = '{ALU_SUB, S2_I1, T_I2, X_I5};
			6'd56: s = '{ALU_ADD, S2_R3, T_R5, X_R3};
			6'd57: s = '{ALU_ADD, S2_I3, T_I5, X_I3};
			6'd58: s = '{ALU_SUB, S2_R3, T_R5, X_R7};
			6'd59: s = '{ALU_SUB, S2_I3, T_I5, X_I7};
			default: s = '{ALU_ADD, X_R0, X_R0, X_R0};
		endcase
		return s;
	endfunction

endpackage

// File: common/fft8_dp_if.sv
interface fft8_dp_if;

	fft8_ucode_pkg::alu_op_e   op;
	fft8_ucode_pkg::reg_addr_e src_a;
	fft8_ucode_pkg::reg_addr_e src_b;
	logic                      wr_en; // qualifies wr_addr, one cycle behind the issue.
	fft8_ucode_pkg::reg_addr_e wr_addr;
	logic                      busy;

	modport seq (
		output op,
		output src_a,
		output src_b,
		output wr_en,
		output wr_addr,
		output busy
	);

	modport dp (
		input op,
		input src_a,
		input src_b,
		input wr_en,
		input wr_addr,
		input busy
	);

endinterface

// File: fft8_ctrl/fft8_sequencer.sv
module fft8_sequencer (
	input  logic   clk,
	input  logic   rst,
	input  logic   start_i,
	fft8_dp_if.seq dp,
	output logic   valid_o
);

	fft8_ucode_pkg::pc_t       pc;
	fft8_ucode_pkg::ustep_t    step;
	fft8_ucode_pkg::reg_addr_e dst_r;
	logic                      start_r;
	logic                      busy_r;
	logic                      run_r;
	logic                      wr_en_r;
	logic                      last_r;
	logic                      valid_r;
	logic                      last_step;

	assign step      = fft8_ucode_pkg::program_step(pc);
	assign last_step = run_r && (pc == fft8_ucode_pkg::pc_t'(fft8_ucode_pkg::PROG_LEN - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			start_r <= 1'b0;
			busy_r  <= 1'b0;
			run_r   <= 1'b0;
			pc      <= '0;
			wr_en_r <= 1'b0;
			last_r  <= 1'b0;
			valid_r <= 1'b0;
		end else begin
			start_r <= start_i && !busy_r; // a start while busy is dropped here.
			if (start_i && !busy_r) begin
				busy_r <= 1'b1;
			end else if (last_r) begin
				busy_r <= 1'b0; // drops together with the rise of valid.
			end
			if (start_r) begin
				run_r <= 1'b1;
			end else if (last_step) begin
				run_r <= 1'b0;
			end
			if (last_step) begin
				pc <= '0;
			end else if (run_r) begin
				pc <= pc + 1'b1;
			end
			wr_en_r <= run_r;
			last_r  <= last_step; // marks the cycle of the final write-back.
			valid_r <= last_r;
		end
	end

	// the ALU result lands one cycle after issue, so the destination follows it.
	always_ff @(posedge clk) begin
		dst_r <= step.dst;
	end

	assign dp.op      = step.op;
	assign dp.src_a   = step.src_a;
	assign dp.src_b   = step.src_b;
	assign dp.wr_en   = wr_en_r;
	assign dp.wr_addr = dst_r;
	assign dp.busy    = busy_r;
	assign valid_o    = valid_r;

endmodule

// File: fft8_datapath/fft8_regbank.sv
module fft8_regbank #(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 14
) (
	input  logic                     clk,
	input  logic                     rst,
	fft8_dp_if.dp                    dp,
	input  logic                     load_i,
	input  fft8_pkg::idx_t           load_idx_i,
	input  logic signed [DATA_W-1:0] load_re_i,
	input  logic signed [DATA_W-1:0] load_im_i,
	input  fft8_pkg::idx_t           rd_idx_i,
	output logic signed [DATA_W-1:0] rd_re_o,
	output logic signed [DATA_W-1:0] rd_im_o,
	input  logic signed [DATA_W-1:0] result_i,
	output logic signed [DATA_W-1:0] opa_o,
	output logic signed [DATA_W-1:0] opb_o
);

	localparam int N_WR = 60; // every address below W1_R is writable.
	localparam int C_INT = fft8_pkg::twiddle_c(FRAC_W);
	localparam logic signed [DATA_W-1:0] W_POS = DATA_W'(C_INT);
	localparam logic signed [DATA_W-1:0] W_NEG = DATA_W'(-C_INT);

	logic signed [DATA_W-1:0] regs [0:N_WR-1];

	// W8^1 = c - jc and W8^3 = -c - jc are fixed words.
	function automatic logic signed [DATA_W-1:0] read_word(
		input fft8_ucode_pkg::reg_addr_e addr
	);
		case (addr)
			fft8_ucode_pkg::W1_R: return W_POS;
			fft8_ucode_pkg::W1_I: return W_NEG;
			fft8_ucode_pkg::W3_R: return W_NEG;
			fft8_ucode_pkg::W3_I: return W_NEG;
			default: return regs[addr];
		endcase
	endfunction

	always_comb begin
		opa_o = read_word(dp.src_a);
		opb_o = read_word(dp.src_b);
	end

	// contents hold while reset is asserted.
	always_ff @(posedge clk) begin
		if (!rst) begin
			if (dp.wr_en) begin
				regs[dp.wr_addr] <= result_i;
			end else if (load_i && !dp.busy) begin
				regs[{load_idx_i, 1'b0}] <= load_re_i;
				regs[{load_idx_i, 1'b1}] <= load_im_i;
			end
		end
	end

	assign rd_re_o = regs[{rd_idx_i, 1'b0}]; // results overwrite the inputs in place.
	assign rd_im_o = regs[{rd_idx_i, 1'b1}];

endmodule

// File: fft8_datapath/fft8_alu.sv
module fft8_alu #(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 14
) (
	input  logic                     clk,
	fft8_dp_if.dp                    dp,
	input  logic signed [DATA_W-1:0] opa_i,
	input  logic signed [DATA_W-1:0] opb_i,
	output logic signed [DATA_W-1:0] result_o
);

	logic signed [2*DATA_W-1:0] prod;
	logic signed [2*DATA_W-1:0] prod_sh;
	logic signed [DATA_W-1:0]   res_d;

	always_comb begin
		prod    = opa_i * opb_i;
		prod_sh = prod >>> FRAC_W; // back to the input scale, rounding toward minus infinity.
		case (dp.op)
			fft8_ucode_pkg::ALU_ADD: res_d = opa_i + opb_i; // sums wrap.
			fft8_ucode_pkg::ALU_SUB: res_d = opa_i - opb_i;
			fft8_ucode_pkg::ALU_MUL: res_d = prod_sh[DATA_W-1:0];
			default: res_d = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		result_o <= res_d;
	end

endmodule

// File: verilog/fft8_top.sv
module fft8_top #(
	parameter int DATA_W = fft8_pkg::DEFAULT_DATA_W,
	parameter int FRAC_W = fft8_pkg::DEFAULT_FRAC_W
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start_i,
	input  logic                     load_i,
	input  fft8_pkg::idx_t           load_idx_i,
	input  logic signed [DATA_W-1:0] load_re_i,
	input  logic signed [DATA_W-1:0] load_im_i,
	input  fft8_pkg::idx_t           rd_idx_i,
	output logic signed [DATA_W-1:0] rd_re_o,
	output logic signed [DATA_W-1:0] rd_im_o,
	output logic                     busy_o,
	output logic                     valid_o
);

	logic signed [DATA_W-1:0] opa;
	logic signed [DATA_W-1:0] opb;
	logic signed [DATA_W-1:0] result;

	fft8_dp_if dp_if ();

	fft8_sequencer i_fft8_sequencer (
		.clk     (clk),
		.rst     (rst),
		.start_i (start_i),
		.dp      (dp_if.seq),
		.valid_o (valid_o)
	);

	fft8_regbank #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) i_fft8_regbank (
		.clk        (clk),
		.rst        (rst),
		.dp         (dp_if.dp),
		.load_i     (load_i),
		.load_idx_i (load_idx_i),
		.load_re_i  (load_re_i),
		.load_im_i  (load_im_i),
		.rd_idx_i   (rd_idx_i),
		.rd_re_o    (rd_re_o),
		.rd_im_o    (rd_im_o),
		.result_i   (result),
		.opa_o      (opa),
		.opb_o      (opb)
	);

	fft8_alu #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) i_fft8_alu (
		.clk      (clk),
		.dp       (dp_if.dp),
		.opa_i    (opa),
		.opb_i    (opb),
		.result_o (result)
	);

	assign busy_o = dp_if.busy;

endmodule

// File: verification/fft8_tb_model.svh
`ifndef FFT8_TB_MODEL_SVH
`define FFT8_TB_MODEL_SVH

function automatic int wrap_word(input longint v);
	logic signed [DATA_W-1:0] w;
	w = v[DATA_W-1:0]; // two's complement wrap to the word width.
	return int'(w);
endfunction

function automatic int fixed_mul(input int a, input int b);
	longint p;
	p = longint'(a) * longint'(b);
	return wrap_word(p >>> FRAC_W);
endfunction

// sum into s, difference into d.
task automatic butterfly(input int ar, input int ai, input int br, input int bi,
		output int sr, output int si, output int dr, output int di);
	sr = wrap_word(ar + br);
	si = wrap_word(ai + bi);
	dr = wrap_word(ar - br);
	di = wrap_word(ai - bi);
endtask

task automatic rotated_butterfly(input int ar, input int ai, input int br, input int bi,
		output int sr, output int si, output int dr, output int di);
	butterfly(ar, ai, bi, -br, sr, si, dr, di); // b is multiplied by -j first.
endtask

task automatic twiddle_mul(input int wr, input int wi, input int ar, input int ai,
		output int pr, output int pi);
	pr = wrap_word(fixed_mul(wr, ar) - fixed_mul(wi, ai));
	pi = wrap_word(fixed_mul(wr, ai) + fixed_mul(wi, ar));
endtask

task automatic compute_fft(input vec8_t xr, input vec8_t xi, output vec8_t yr, output vec8_t yi);
	vec8_t s1r, s1i, s2r, s2i;
	int c;
	int t5r, t5i, t7r, t7i;
	c = fft8_pkg::twiddle_c(FRAC_W);
	butterfly(xr[0], xi[0], xr[4], xi[4], s1r[0], s1i[0], s1r[1], s1i[1]);
	butterfly(xr[2], xi[2], xr[6], xi[6], s1r[2], s1i[2], s1r[3], s1i[3]);
	butterfly(xr[1], xi[1], xr[5], xi[5], s1r[4], s1i[4], s1r[5], s1i[5]);
	butterfly(xr[3], xi[3], xr[7], xi[7], s1r[6], s1i[6], s1r[7], s1i[7]);
	butterfly(s1r[0], s1i[0], s1r[2], s1i[2], s2r[0], s2i[0], s2r[2], s2i[2]);
	rotated_butterfly(s1r[1], s1i[1], s1r[3], s1i[3], s2r[1], s2i[1], s2r[3], s2i[3]);
	butterfly(s1r[4], s1i[4], s1r[6], s1i[6], s2r[4], s2i[4], s2r[6], s2i[6]);
	rotated_butterfly(s1r[5], s1i[5], s1r[7], s1i[7], s2r[5], s2i[5], s2r[7], s2i[7]);
	twiddle_mul(c, -c, s2r[5], s2i[5], t5r, t5i); // W8^1 = c - jc.
	twiddle_mul(-c, -c, s2r[7], s2i[7], t7r, t7i); // W8^3 = -c - jc.
	butterfly(s2r[0], s2i[0], s2r[4], s2i[4], yr[0], yi[0], yr[4], yi[4]);
	rotated_butterfly(s2r[2], s2i[2], s2r[6], s2i[6], yr[2], yi[2], yr[6], yi[6]);
	butterfly(s2r[1], s2i[1], t5r, t5i, yr[1], yi[1], yr[5], yi[5]);
	butterfly(s2r[3], s2i[3], t7r, t7i, yr[3], yi[3], yr[7], yi[7]);
endtask

`endif

// File: verification/fft8_tb.sv
module fft8_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_W = fft8_pkg::DEFAULT_DATA_W;
	localparam int FRAC_W = fft8_pkg::DEFAULT_FRAC_W;
	localparam int NUM_VEC = 6;
	localparam int TIMEOUT = 100;
	localparam int LATENCY = fft8_ucode_pkg::PROG_LEN + 2;

	typedef int vec8_t [8];

	logic                     clk;
	logic                     rst;
	logic                     start_i;
	logic                     load_i;
	fft8_pkg::idx_t           load_idx_i;
	logic signed [DATA_W-1:0] load_re_i;
	logic signed [DATA_W-1:0] load_im_i;
	fft8_pkg::idx_t           rd_idx_i;
	logic signed [DATA_W-1:0] rd_re_o;
	logic signed [DATA_W-1:0] rd_im_o;
	logic                     busy_o;
	logic                     valid_o;
	logic [15:0]              lfsr;

	// rows 0 to 2 are impulse, constant and alternating input, the rest are random.
	bit is_rand [NUM_VEC] = '{0, 0, 0, 1, 1, 1};
	bit disturb [NUM_VEC] = '{0, 0, 0, 0, 1, 0}; // start and load pulses while busy.
	vec8_t in_re [NUM_VEC] = '{
		'{1000, 0, 0, 0, 0, 0, 0, 0},
		'{8{300}},
		'{450, -450, 450, -450, 450, -450, 450, -450},
		'{8{0}}, '{8{0}}, '{8{0}}
	};
	vec8_t in_im [NUM_VEC] = '{
		'{-700, 0, 0, 0, 0, 0, 0, 0},
		'{8{-125}},
		'{90, -90, 90, -90, 90, -90, 90, -90},
		'{8{0}}, '{8{0}}, '{8{0}}
	};
	vec8_t exp_re [NUM_VEC] = '{
		'{8{1000}},
		'{2400, 0, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 3600, 0, 0, 0},
		'{8{0}}, '{8{0}}, '{8{0}}
	};
	vec8_t exp_im [NUM_VEC] = '{
		'{8{-700}},
		'{-1000, 0, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 720, 0, 0, 0},
		'{8{0}}, '{8{0}}, '{8{0}}
	};

	`include "fft8_tb_model.svh"

	fft8_top i_fft8_top (
		.clk        (clk),
		.rst        (rst),
		.start_i    (start_i),
		.load_i     (load_i),
		.load_idx_i (load_idx_i),
		.load_re_i  (load_re_i),
		.load_im_i  (load_im_i),
		.rd_idx_i   (rd_idx_i),
		.rd_re_o    (rd_re_o),
		.rd_im_o    (rd_im_o),
		.busy_o     (busy_o),
		.valid_o    (valid_o)
	);

	always #2 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1.
	endfunction

	// one lfsr step per bit, the value stays within +-2^(DATA_W-4).
	task automatic random_sample(output int v);
		v = 0;
		for (int i = 0; i < DATA_W - 3; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
		if (v >= 2 ** (DATA_W - 4)) begin
			v = v - 2 ** (DATA_W - 3);
		end
	endtask

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic load_samples(input int v);
		for (int k = 0; k < fft8_pkg::N_POINTS; k++) begin
			@(negedge clk);
			load_i = 1'b1;
			load_idx_i = fft8_pkg::idx_t'(k);
			load_re_i = DATA_W'(in_re[v][k]);
			load_im_i = DATA_W'(in_im[v][k]);
		end
		@(negedge clk);
		load_i = 1'b0;
	endtask

	task automatic run_transform(input int v);
		int cycles;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		cycles = 0; // rising edges counted after the one that sampled start.
		while (valid_o !== 1'b1) begin
			if (cycles >= TIMEOUT) begin
				$display("valid_o never arrived within %0d cycles after start", TIMEOUT);
				abort_run();
			end
			check_value("busy_o", busy_o, 1);
			// the early load hits inputs still to be read, the late one hits finished results.
			if (disturb[v] && (cycles == 0 || cycles == 55)) begin
				start_i = 1'b1;
				load_i = 1'b1;
				load_idx_i = '0;
				load_re_i = 1234;
				load_im_i = -1234;
			end else begin
				start_i = 1'b0;
				load_i = 1'b0;
			end
			@(negedge clk);
			cycles++;
		end
		start_i = 1'b0;
		load_i = 1'b0;
		check_value("valid_o latency", cycles, LATENCY);
		check_value("busy_o", busy_o, 0);
		@(negedge clk);
		check_value("valid_o", valid_o, 0); // the pulse lasts one cycle.
	endtask

	task automatic read_results(input int v);
		for (int k = 0; k < fft8_pkg::N_POINTS; k++) begin
			rd_idx_i = fft8_pkg::idx_t'(k);
			@(negedge clk);
			check_value($sformatf("rd_re_o[%0d]", k), rd_re_o, exp_re[v][k]);
			check_value($sformatf("rd_im_o[%0d]", k), rd_im_o, exp_im[v][k]);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start_i = 1'b0;
		load_i = 1'b0;
		load_idx_i = '0;
		load_re_i = '0;
		load_im_i = '0;
		rd_idx_i = '0;
		lfsr = 16'd22;
		for (int v = 0; v < NUM_VEC; v++) begin
			if (is_rand[v]) begin
				for (int k = 0; k < fft8_pkg::N_POINTS; k++) begin
					random_sample(in_re[v][k]);
					random_sample(in_im[v][k]);
				end
				compute_fft(in_re[v], in_im[v], exp_re[v], exp_im[v]);
			end
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("busy_o", busy_o, 0);
		check_value("valid_o", valid_o, 0);
		for (int v = 0; v < NUM_VEC; v++) begin
			load_samples(v);
			run_transform(v);
			read_results(v);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: files.f
common/fft8_pkg.sv
common/fft8_ucode_pkg.sv
common/fft8_dp_if.sv
fft8_ctrl/fft8_sequencer.sv
fft8_datapath/fft8_regbank.sv
fft8_datapath/fft8_alu.sv
verilog/fft8_top.sv
+incdir+verification
verification/fft8_tb.sv

// File: Bender.yml
package:
  name: fft8

sources:
  - files:
      - common/fft8_pkg.sv
      - common/fft8_ucode_pkg.sv
      - common/fft8_dp_if.sv
      - fft8_ctrl/fft8_sequencer.sv
      - fft8_datapath/fft8_regbank.sv
      - fft8_datapath/fft8_alu.sv
      - verilog/fft8_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/fft8_tb.sv
